// File: include/dcache_defs.svh
/* Data cache build parameters
   Word width, set count and write-buffer depth */

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// ##############################
// Datapath

// Bus word width in bits
`define DCACHE_WORDBITS 32

// ##############################
// Cache geometry

// Direct-mapped, power of two
`define DCACHE_SETCOUNT 16

// Pending memory writes
`define DCACHE_WBUF_DEPTH 4

`endif

// File: hdl/dcache_pkg.sv
/* Data cache types
   Bus widths, PI1 operations, controller states and request records */

`include "dcache_defs.svh"

package dcache_pkg;

	// ##############################
	// Widths

	typedef logic [`DCACHE_WORDBITS-1:0] word_t;
	typedef logic [`DCACHE_WORDBITS-3:0] addr_t; // Word address
	typedef logic [`DCACHE_WORDBITS/8-1:0] sel_t;
	typedef logic [`DCACHE_WORDBITS/8-1:0] mask_t; // One valid bit per byte
	typedef logic [$clog2(`DCACHE_SETCOUNT)-1:0] index_t;
	typedef logic [`DCACHE_WORDBITS-3-$clog2(`DCACHE_SETCOUNT):0] tag_t;

	// ##############################
	// PI1 operations, 2'b11 reserved

	typedef enum logic [1:0] {
		PI_NOOP = 2'd0,
		PI_WR   = 2'd1,
		PI_RD   = 2'd2
	} pi_op_e;

	// One request on either bus side
	typedef struct packed {
		pi_op_e op;
		addr_t  addr;
		word_t  data;
		sel_t   sel;
	} pi_req_t;

	// Write waiting for the memory port
	typedef struct packed {
		addr_t addr;
		word_t data;
		sel_t  sel;
	} wbuf_entry_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DRAIN, // Miss, buffer still draining
		ST_FETCH, // Read issued to memory
		ST_WAIT   // Buffer almost full
	} ctrl_state_e;

endpackage

// File: hdl/dcache_sweep.sv
`timescale 1ns/100ps

/* Invalidation sweep
   Walks every set index down to zero after reset or cache reset */

`include "dcache_defs.svh"

module dcache_sweep
	import dcache_pkg::*;
#(
	parameter int SETCOUNT = `DCACHE_SETCOUNT
) (
	input  logic   clk_i,
	input  logic   rst_i,
	input  logic   crst_i,
	output logic   busy_o,
	output index_t idx_o
);

	index_t idx_q;
	logic   busy_q;

	always_ff @(posedge clk_i) begin
		if (rst_i || crst_i) begin
			idx_q  <= index_t'(SETCOUNT - 1); // Top set first
			busy_q <= 1'b1;
		end else if (busy_q) begin
			if (idx_q == '0)
				busy_q <= 1'b0;
			else
				idx_q <= idx_q - 1'b1;
		end
	end

	assign busy_o = busy_q;
	assign idx_o  = idx_q;

endmodule

// File: hdl/dcache_store.sv
`timescale 1ns/100ps

/* Cache line store
   Tag, data and byte-valid arrays with registered lookup and merging write */

`include "dcache_defs.svh"

module dcache_store
	import dcache_pkg::*;
#(
	parameter int SETCOUNT = `DCACHE_SETCOUNT
) (
	input  logic   clk_i,
	input  logic   lk_en_i,
	input  addr_t  lk_addr_i,
	input  sel_t   lk_sel_i,
	output logic   hit_o,
	output word_t  rd_data_o,
	input  logic   we_i,
	input  logic   fill_i,
	input  addr_t  wr_addr_i,
	input  word_t  wr_data_i,
	input  sel_t   wr_sel_i,
	input  logic   inv_i,
	input  index_t inv_idx_i
);

	localparam int IW = $bits(index_t);

	tag_t  tags  [SETCOUNT];
	word_t datas [SETCOUNT];
	mask_t masks [SETCOUNT];

	index_t lk_idx;
	index_t wr_idx;
	tag_t   lk_tag;
	tag_t   wr_tag;
	word_t  bmask;
	word_t  wr_data_n;
	mask_t  wr_mask_n;
	mask_t  lk_mask_n;
	logic   fwd;

	// Registered lookup
	tag_t   lk_tag_q;
	sel_t   lk_sel_q;
	tag_t   line_tag_q;
	word_t  line_data_q;
	mask_t  line_mask_q;

	assign lk_idx = lk_addr_i[IW-1:0];
	assign lk_tag = lk_addr_i[$bits(addr_t)-1:IW];
	assign wr_idx = wr_addr_i[IW-1:0];
	assign wr_tag = wr_addr_i[$bits(addr_t)-1:IW];

	// ##############################
	// Byte merge

	always_comb begin
		for (int b = 0; b < $bits(sel_t); b++)
			bmask[8*b +: 8] = {8{wr_sel_i[b]}};
		if (fill_i) begin
			wr_data_n = wr_data_i;
			wr_mask_n = '1;
		end else if (tags[wr_idx] == wr_tag) begin
			wr_data_n = (datas[wr_idx] & ~bmask) | (wr_data_i & bmask);
			wr_mask_n = masks[wr_idx] | wr_sel_i;
		end else begin
			wr_data_n = wr_data_i; // Retag with only the written bytes valid
			wr_mask_n = wr_sel_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			tags[wr_idx]  <= wr_tag;
			datas[wr_idx] <= wr_data_n;
		end
		for (int s = 0; s < SETCOUNT; s++) begin
			if (inv_i && (inv_idx_i == index_t'(s)))
				masks[s] <= '0;
			else if (we_i && (wr_idx == index_t'(s)))
				masks[s] <= wr_mask_n;
		end
	end

	// ##############################
	// Lookup with same-edge forwarding

	assign fwd       = we_i && (wr_idx == lk_idx);
	assign lk_mask_n = (inv_i && (inv_idx_i == lk_idx)) ? '0 : (fwd ? wr_mask_n : masks[lk_idx]);

	always_ff @(posedge clk_i) begin
		if (lk_en_i) begin
			lk_tag_q    <= lk_tag;
			lk_sel_q    <= lk_sel_i;
			line_tag_q  <= fwd ? wr_tag : tags[lk_idx];
			line_data_q <= fwd ? wr_data_n : datas[lk_idx];
			line_mask_q <= lk_mask_n;
		end
	end

	assign hit_o     = (line_tag_q == lk_tag_q) && ((line_mask_q & lk_sel_q) == lk_sel_q);
	assign rd_data_o = line_data_q;

endmodule

// File: hdl/dcache_wbuf.sv
`timescale 1ns/100ps

/* Write buffer
   First-word-fall-through FIFO of writes pending on the memory port */

`include "dcache_defs.svh"

module dcache_wbuf
	import dcache_pkg::*;
#(
	parameter int DEPTH = `DCACHE_WBUF_DEPTH
) (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        push_i,
	input  wbuf_entry_t entry_i,
	input  logic        pop_i,
	output wbuf_entry_t head_o,
	output logic        empty_o,
	output logic        afull_o
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	wbuf_entry_t   mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;

	// Ring wrap, DEPTH need not be a power of two
	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop_i)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i)
			mem[wr_ptr] <= entry_i;
	end

	assign head_o  = mem[rd_ptr]; // Valid while not empty
	assign empty_o = (count == '0);
	assign afull_o = (count >= CW'(DEPTH - 1));

endmodule

// File: hdl/dcache_ctrl.sv
`timescale 1ns/100ps

/* Data cache controller
   Accepts processor requests, resolves hit or miss and arbitrates the memory port */

module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cenable_i,
	input  logic        sweep_busy_i,
	input  pi_req_t     m_req_i,
	output word_t       m_data_o,
	output logic        m_rdy_o,
	output pi_req_t     s_req_o,
	input  word_t       s_data_i,
	input  logic        s_rdy_i,
	output logic        lk_en_o,
	output addr_t       lk_addr_o,
	output sel_t        lk_sel_o,
	input  logic        hit_i,
	input  word_t       lk_data_i,
	output logic        st_we_o,
	output logic        st_fill_o,
	output addr_t       st_addr_o,
	output word_t       st_data_o,
	output sel_t        st_sel_o,
	output logic        wb_push_o,
	output wbuf_entry_t wb_entry_o,
	input  wbuf_entry_t wb_head_i,
	input  logic        wb_empty_i,
	input  logic        wb_afull_i,
	output logic        wb_pop_o
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	pi_req_t     req_q;
	logic        new_q;   // req_q accepted on the last edge
	logic        cache_q; // Caching allowed when req_q was accepted
	logic        accept;
	logic        miss_now;
	logic        rd_issue;
	logic        wr_issue;
	logic        fill_now;

	assign accept = m_rdy_o && (m_req_i.op != PI_NOOP);

	// Store result is due the cycle after a read is accepted
	assign miss_now = new_q && (req_q.op == PI_RD) && (!cache_q || !hit_i);

	// ##############################
	// Processor side

	always_comb begin
		case (state_q)
			ST_IDLE:  m_rdy_o = !miss_now && !wb_afull_i;
			ST_FETCH: m_rdy_o = s_rdy_i; // Fill word on s_data_i
			default:  m_rdy_o = 1'b0;
		endcase
	end

	assign m_data_o = (state_q == ST_FETCH) ? s_data_i : lk_data_i;

	assign lk_en_o   = accept;
	assign lk_addr_o = m_req_i.addr;
	assign lk_sel_o  = m_req_i.sel;

	assign wb_push_o       = accept && (m_req_i.op == PI_WR);
	assign wb_entry_o.addr = m_req_i.addr;
	assign wb_entry_o.data = m_req_i.data;
	assign wb_entry_o.sel  = m_req_i.sel;

	// ##############################
	// Memory side

	assign wr_issue = !wb_empty_i && (state_q != ST_FETCH);
	assign rd_issue = (state_q == ST_DRAIN) && wb_empty_i;
	assign wb_pop_o = wr_issue && s_rdy_i;

	always_comb begin
		s_req_o.data = wb_head_i.data;
		if (wr_issue) begin
			s_req_o.op   = PI_WR;
			s_req_o.addr = wb_head_i.addr;
			s_req_o.sel  = wb_head_i.sel;
		end else begin
			s_req_o.op   = rd_issue ? PI_RD : PI_NOOP;
			s_req_o.addr = req_q.addr;
			s_req_o.sel  = '1; // Whole word for the fill
		end
	end

	// Writes update the store one edge after acceptance
	assign fill_now  = (state_q == ST_FETCH) && s_rdy_i && cache_q && cenable_i && !sweep_busy_i;
	assign st_we_o   = (new_q && (req_q.op == PI_WR)) || fill_now;
	assign st_fill_o = fill_now;
	assign st_addr_o = req_q.addr;
	assign st_data_o = fill_now ? s_data_i : req_q.data;
	assign st_sel_o  = fill_now ? '1 : req_q.sel;

	// ##############################
	// FSM

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (miss_now)
					state_d = ST_DRAIN;
				else if (wb_afull_i)
					state_d = ST_WAIT;
			end
			ST_DRAIN: begin
				if (rd_issue && s_rdy_i)
					state_d = ST_FETCH;
			end
			ST_FETCH: begin
				if (s_rdy_i)
					state_d = ST_IDLE;
			end
			default: begin
				if (!wb_afull_i)
					state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= ST_IDLE;
			new_q   <= 1'b0;
			cache_q <= 1'b0;
		end else begin
			state_q <= state_d;
			new_q   <= accept;
			if (accept)
				cache_q <= cenable_i && !sweep_busy_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept)
			req_q <= m_req_i;
	end

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/100ps

/* PI1 data cache
   Direct-mapped write-through cache between the load/store port and memory */

`include "dcache_defs.svh"

module dcache_top
	import dcache_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    crst_i,
	input  logic    cenable_i,
	input  pi_req_t m_req_i,
	output word_t   m_data_o,
	output logic    m_rdy_o,
	output pi_req_t s_req_o,
	input  word_t   s_data_i,
	input  logic    s_rdy_i
);

	logic        lk_en;
	addr_t       lk_addr;
	sel_t        lk_sel;
	logic        hit;
	word_t       lk_data;
	logic        st_we;
	logic        st_fill;
	addr_t       st_addr;
	word_t       st_data;
	sel_t        st_sel;
	logic        wb_push;
	wbuf_entry_t wb_entry;
	wbuf_entry_t wb_head;
	logic        wb_empty;
	logic        wb_afull;
	logic        wb_pop;
	logic        sweep_busy;
	index_t      sweep_idx;

	dcache_ctrl u_ctrl (
		.clk_i(clk_i), .rst_i(rst_i), .cenable_i(cenable_i), .sweep_busy_i(sweep_busy),
		.m_req_i(m_req_i), .m_data_o(m_data_o), .m_rdy_o(m_rdy_o),
		.s_req_o(s_req_o), .s_data_i(s_data_i), .s_rdy_i(s_rdy_i),
		.lk_en_o(lk_en), .lk_addr_o(lk_addr), .lk_sel_o(lk_sel),
		.hit_i(hit), .lk_data_i(lk_data),
		.st_we_o(st_we), .st_fill_o(st_fill), .st_addr_o(st_addr),
		.st_data_o(st_data), .st_sel_o(st_sel),
		.wb_push_o(wb_push), .wb_entry_o(wb_entry), .wb_head_i(wb_head),
		.wb_empty_i(wb_empty), .wb_afull_i(wb_afull), .wb_pop_o(wb_pop)
	);

	dcache_sweep #(.SETCOUNT(`DCACHE_SETCOUNT)) u_sweep (
		.clk_i(clk_i), .rst_i(rst_i), .crst_i(crst_i),
		.busy_o(sweep_busy), .idx_o(sweep_idx)
	);

	dcache_store #(.SETCOUNT(`DCACHE_SETCOUNT)) u_store (
		.clk_i(clk_i), .lk_en_i(lk_en), .lk_addr_i(lk_addr), .lk_sel_i(lk_sel),
		.hit_o(hit), .rd_data_o(lk_data),
		.we_i(st_we), .fill_i(st_fill), .wr_addr_i(st_addr),
		.wr_data_i(st_data), .wr_sel_i(st_sel),
		.inv_i(sweep_busy), .inv_idx_i(sweep_idx)
	);

	dcache_wbuf #(.DEPTH(`DCACHE_WBUF_DEPTH)) u_wbuf (
		.clk_i(clk_i), .rst_i(rst_i), .push_i(wb_push), .entry_i(wb_entry),
		.pop_i(wb_pop), .head_o(wb_head), .empty_o(wb_empty), .afull_o(wb_afull)
	);

endmodule

// File: testbench/tb_clkgen.sv
`timescale 1ns/100ps

/* Testbench clock and reset
   8 ns clock, reset held over the first 3 rising edges */

module tb_clkgen #(
	parameter int HALF_NS    = 4,
	parameter int RST_CYCLES = 3
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(HALF_NS) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_o <= 1'b0; // Released on a falling edge
	end

endmodule

// File: testbench/dcache_tb.sv
`timescale 1ns/100ps

/* Data cache testbench
   Plays the request trace against the cache and a 64-word memory model */

`include "dcache_defs.svh"

module dcache_tb
	import dcache_pkg::*;
();

	localparam int TIMEOUT  = 500;
	localparam int MEMWORDS = 64;

	logic    clk;
	logic    rst;
	logic    crst;
	logic    cenable;
	pi_req_t m_req;
	word_t   m_data;
	logic    m_rdy;
	pi_req_t s_req;
	word_t   s_data = '0;
	logic    s_rdy;
	logic    hold_lo; // Memory stalled by the trace
	int      seed;

	word_t mem [MEMWORDS];
	int    bus_reads;
	int    bus_writes;

	string cur_name;
	int    tests;
	int    failed_tests;
	int    errors;
	int    test_errors;
	int    base_reads;
	int    base_writes;
	bit    timed_out;

	tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

	dcache_top u_dut (
		.clk_i(clk), .rst_i(rst), .crst_i(crst), .cenable_i(cenable),
		.m_req_i(m_req), .m_data_o(m_data), .m_rdy_o(m_rdy),
		.s_req_o(s_req), .s_data_i(s_data), .s_rdy_i(s_rdy)
	);

	// ##############################
	// Memory model

	always @(posedge clk) begin
		if (rst) begin
			for (int a = 0; a < MEMWORDS; a++)
				mem[a] <= word_t'(a) ^ 32'h5a5a0000;
			s_data     <= '0;
			bus_reads  <= 0;
			bus_writes <= 0;
		end else if (s_rdy && (s_req.op == PI_RD)) begin
			s_data    <= mem[s_req.addr[5:0]]; // Held until the next read
			bus_reads <= bus_reads + 1;
		end else if (s_rdy && (s_req.op == PI_WR)) begin
			for (int b = 0; b < 4; b++)
				if (s_req.sel[b])
					mem[s_req.addr[5:0]][8*b +: 8] <= s_req.data[8*b +: 8];
			bus_writes <= bus_writes + 1;
		end
	end

	// ##############################
	// Stimulus helpers

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic stall(input string what);
		$display("Timeout in %s: %s", cur_name, what);
		note_error();
		timed_out = 1'b1;
	endtask

	// One cycle with outputs sampled 1 ns after the falling edge
	task automatic fall_edge(input pi_req_t req);
		@(negedge clk);
		s_rdy = !hold_lo && (($random(seed) & 3) != 0); // Ready about 3 cycles in 4
		m_req = req;
		#1;
	endtask

	task automatic send(input pi_req_t req);
		bit taken;
		taken = 1'b0;
		for (int n = 0; n < TIMEOUT && !taken; n++) begin
			fall_edge(req);
			taken = m_rdy;
		end
		if (!taken)
			stall("m_rdy_o never rose for the request");
	endtask

	task automatic collect(output word_t data);
		bit got;
		got  = 1'b0;
		data = '0;
		for (int n = 0; n < TIMEOUT && !got; n++) begin
			fall_edge('0);
			got  = m_rdy;
			data = m_data;
		end
		if (!got)
			stall("read data never returned");
	endtask

	// Waits until the write buffer has drained
	task automatic settle();
		bit quiet;
		quiet = 1'b0;
		for (int n = 0; n < TIMEOUT && !quiet; n++) begin
			fall_edge('0);
			quiet = m_rdy && (s_req.op == PI_NOOP);
		end
		if (!quiet)
			stall("memory port never went idle");
	endtask

	// ##############################
	// Trace steps

	task automatic run_step(input string op, input addr_t addr, input word_t data,
		input sel_t sel, input word_t exp_val);
		pi_req_t req;
		word_t   got;
		word_t   keep;
		req.op   = PI_NOOP;
		req.addr = addr;
		req.data = data;
		req.sel  = sel;
		for (int b = 0; b < 4; b++)
			keep[8*b +: 8] = {8{sel[b]}}; // Only selected bytes are compared
		got = '0;
		if (op == "RD") begin
			req.op = PI_RD;
			send(req);
			if (!timed_out)
				collect(got);
			if (!timed_out && ((got & keep) !== (exp_val & keep))) begin
				$display("** Error [%s] read %h: expected %h, actual %h", cur_name, addr,
					exp_val & keep, got & keep);
				note_error();
			end
		end else if (op == "WR") begin
			req.op = PI_WR;
			send(req);
		end else if (op == "CNT") begin
			settle();
			if (!timed_out && (bus_reads - base_reads != int'(data))) begin
				$display("** Error [%s] bus reads: expected %0d, actual %0d", cur_name,
					int'(data), bus_reads - base_reads);
				note_error();
			end
			if (!timed_out && (bus_writes - base_writes != int'(exp_val))) begin
				$display("** Error [%s] bus writes: expected %0d, actual %0d", cur_name,
					int'(exp_val), bus_writes - base_writes);
				note_error();
			end
		end else if (op == "HOLD") begin
			hold_lo = data[0];
			fall_edge('0);
		end else if (op == "BUSY") begin
			fall_edge('0);
			if (m_rdy) begin
				$display("Error in %s: m_rdy_o stayed high with the write buffer full",
					cur_name);
				note_error();
			end
		end else if (op == "CRST") begin
			@(negedge clk);
			m_req = '0;
			crst  = 1'b1;
			@(negedge clk);
			crst = 1'b0;
			repeat (`DCACHE_SETCOUNT + 2) fall_edge('0); // Sweep length
		end else if (op == "CEN") begin
			@(negedge clk);
			m_req   = '0;
			cenable = data[0];
		end else begin
			$display("Error in %s: unknown trace operation %s", cur_name, op);
			note_error();
		end
	endtask

	task automatic open_test(input string name);
		cur_name    = name;
		test_errors = 0;
		base_reads  = bus_reads;
		base_writes = bus_writes;
	endtask

	task automatic close_test();
		tests++;
		if (test_errors != 0) begin
			failed_tests++;
			$display("%s: FAIL, %0d errors", cur_name, test_errors);
		end else begin
			$display("%s: ok", cur_name);
		end
	endtask

	// ##############################
	// Trace player

	initial begin
		int    fd;
		string line;
		string name;
		string op;
		addr_t addr;
		word_t data;
		sel_t  sel;
		word_t exp_val;
		m_req     = '0;
		s_rdy     = 1'b0;
		crst      = 1'b0;
		cenable   = 1'b1;
		hold_lo   = 1'b0;
		seed      = 32'h4cc4;
		cur_name  = "";
		tests     = 0;
		errors    = 0;
		timed_out = 1'b0;
		failed_tests = 0;
		fall_edge('0);
		for (int n = 0; n < TIMEOUT && rst; n++)
			fall_edge('0);
		if (rst)
			stall("reset never released");
		repeat (`DCACHE_SETCOUNT + 2) fall_edge('0); // Sweep after reset
		fd = $fopen("testbench/dcache_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open testbench/dcache_trace.txt");
			errors++;
		end
		while (fd != 0 && !timed_out && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#" &&
				$sscanf(line, "%s %s %h %h %h %h", name, op, addr, data, sel, exp_val) == 6) begin
				if (name != cur_name) begin
					if (cur_name != "")
						close_test();
					open_test(name);
				end
				run_step(op, addr, data, sel, exp_val);
			end
		end
		if (cur_name != "")
			close_test();
		if (fd != 0)
			$fclose(fd);
		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0 && !timed_out && tests > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: testbench/dcache_trace.txt
# name op addr data sel expect, all hex, addr is a word address
# CNT checks bus reads (data) and bus writes (expect) since the test began
cold_read       RD   05 00000000 f 5a5a0005
cold_read       RD   05 00000000 f 5a5a0005
cold_read       RD   16 00000000 f 5a5a0016
cold_read       RD   16 00000000 f 5a5a0016
cold_read       CNT  00 00000002 0 00000000
partial_write   WR   05 0000beef 3 00000000
partial_write   RD   05 00000000 f 5a5abeef
partial_write   WR   08 12340000 c 00000000
partial_write   RD   08 00000000 c 12340000
partial_write   CNT  00 00000000 0 00000002
unwritten_bytes WR   0a 000000a1 1 00000000
unwritten_bytes RD   0a 00000000 e 5a5a00a1
unwritten_bytes RD   0a 00000000 f 5a5a00a1
unwritten_bytes CNT  00 00000001 0 00000001
buffer_full     HOLD 00 00000001 0 00000000
buffer_full     WR   23 00000011 1 00000000
buffer_full     WR   23 00002200 2 00000000
buffer_full     WR   23 00003344 3 00000000
buffer_full     BUSY 00 00000000 0 00000000
buffer_full     HOLD 00 00000000 0 00000000
buffer_full     WR   23 00550000 4 00000000
buffer_full     RD   23 00000000 f 5a553344
buffer_full     CNT  00 00000001 0 00000004
cache_reset     RD   16 00000000 f 5a5a0016
cache_reset     CRST 00 00000000 0 00000000
cache_reset     RD   16 00000000 f 5a5a0016
cache_reset     RD   16 00000000 f 5a5a0016
cache_reset     CNT  00 00000001 0 00000000
cache_disabled  CEN  00 00000000 0 00000000
cache_disabled  RD   05 00000000 f 5a5abeef
cache_disabled  RD   05 00000000 f 5a5abeef
cache_disabled  WR   05 00c00000 4 00000000
cache_disabled  RD   05 00000000 f 5ac0beef
cache_disabled  CNT  00 00000003 0 00000001
cache_enabled   CEN  00 00000001 0 00000000
cache_enabled   RD   05 00000000 f 5ac0beef
cache_enabled   RD   05 00000000 f 5ac0beef
cache_enabled   CNT  00 00000001 0 00000000

// File: dcache_top.f
+incdir+include
hdl/dcache_pkg.sv
hdl/dcache_sweep.sv
hdl/dcache_store.sv
hdl/dcache_wbuf.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
testbench/tb_clkgen.sv
testbench/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0
TOP       := dcache_tb
FILELIST  := dcache_top.f
OBJDIR    := obj_dir

BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep '\.sv$$' $(FILELIST))
HEADERS := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q '^test passed$$' && ! echo "$$out" | grep -q '^test failed$$'

clean:
	rm -rf $(OBJDIR)
